// ==== design/mon_config.svh ====
`ifndef MON_CONFIG_SVH
`define MON_CONFIG_SVH

// Instruction words that end a program run
// beq x0, x0, 0
`define MON_HALT_INSN0 32'h00000063
// jal x0, 0
`define MON_HALT_INSN1 32'h0000006f
// slti x0, x0, -256
`define MON_HALT_INSN2 32'hF0002013

// Segment markers are slti to x0 with small immediates, so they have no side effect
`define MON_SEG_START_INSN 32'h00102013
`define MON_SEG_STOP_INSN  32'h00202013

// Width of the segment instruction and cycle counters
`define MON_COUNT_W 32

`endif

// ==== design/mon_pkg.sv ====
`default_nettype none

`include "mon_config.svh"

package mon_pkg;

    // Commit order number as reported by the core
    typedef logic [63:0] order_t;

    // Instruction, PC, data and address words
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_idx_t;

    typedef logic [`MON_COUNT_W-1:0] count_t;

    // Classification attached to each record by the second stage
    typedef enum logic [1:0] {
        TAG_PLAIN,
        TAG_HALT,
        TAG_SEG_START,
        TAG_SEG_STOP
    } commit_tag_e;

endpackage

`default_nettype wire

// ==== design/commit_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface commit_if;
    import mon_pkg::*;

    logic        valid;
    order_t      order;
    word_t       insn;
    word_t       pc;
    reg_idx_t    rd_addr;
    word_t       rd_wdata;
    word_t       mem_addr;
    commit_tag_e tag;

    modport src (
        output valid, order, insn, pc, rd_addr, rd_wdata, mem_addr, tag
    );

    modport snk (
        input valid, order, insn, pc, rd_addr, rd_wdata, mem_addr, tag
    );

endinterface

`default_nettype wire

// ==== design/commit_normalize.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_normalize (
    input  logic              itf,
    input  logic              arst_n,
    input  logic              commit_valid,
    input  mon_pkg::order_t   commit_order,
    input  mon_pkg::word_t    commit_insn,
    input  mon_pkg::word_t    commit_pc,
    input  mon_pkg::reg_idx_t commit_rd_addr,
    input  mon_pkg::word_t    commit_rd_wdata,
    input  mon_pkg::word_t    commit_mem_addr,
    commit_if.src             out
);
    import mon_pkg::*;

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= commit_valid;
        end
    end

    always_ff @(posedge itf) begin
        out.order   <= commit_order;
        out.insn    <= commit_insn;
        out.pc      <= commit_pc;
        out.rd_addr <= commit_rd_addr;
        // A write to x0 is architecturally discarded, so report it as zero
        if (commit_rd_addr != '0) begin
            out.rd_wdata <= commit_rd_wdata;
        end else begin
            out.rd_wdata <= '0;
        end
        // Byte offset within the word is dropped
        out.mem_addr <= {commit_mem_addr[31:2], 2'b00};
    end

    // Classification happens in the next stage
    assign out.tag = TAG_PLAIN;

endmodule

`default_nettype wire

// ==== design/commit_classify.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mon_config.svh"

module commit_classify (
    input  logic  itf,
    input  logic  arst_n,
    commit_if.snk in,
    commit_if.src out
);
    import mon_pkg::*;

    commit_tag_e tag_next;

    always_comb begin
        tag_next = TAG_PLAIN;
        if (in.valid) begin
            if (in.insn == `MON_HALT_INSN0 ||
                in.insn == `MON_HALT_INSN1 ||
                in.insn == `MON_HALT_INSN2) begin
                tag_next = TAG_HALT;
            end else if (in.insn == `MON_SEG_START_INSN) begin
                tag_next = TAG_SEG_START;
            end else if (in.insn == `MON_SEG_STOP_INSN) begin
                tag_next = TAG_SEG_STOP;
            end
        end
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            out.valid <= 1'b0;
            out.tag   <= TAG_PLAIN;
        end else begin
            out.valid <= in.valid;
            out.tag   <= tag_next;
        end
    end

    always_ff @(posedge itf) begin
        out.order    <= in.order;
        out.insn     <= in.insn;
        out.pc       <= in.pc;
        out.rd_addr  <= in.rd_addr;
        out.rd_wdata <= in.rd_wdata;
        out.mem_addr <= in.mem_addr;
    end

endmodule

`default_nettype wire

// ==== design/segment_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module segment_counter (
    input  logic            itf,
    input  logic            arst_n,
    commit_if.snk           in,
    output logic            halted,
    output logic            seg_done,
    output mon_pkg::count_t seg_inst_count,
    output mon_pkg::count_t seg_cycle_count
);
    import mon_pkg::*;

    typedef enum logic {
        SEG_IDLE,
        SEG_RUN
    } seg_state_e;

    seg_state_e state;
    count_t     inst_cnt;
    count_t     cycle_cnt;
    logic       is_start;
    logic       is_stop;

    assign is_start = in.valid && (in.tag == TAG_SEG_START);
    assign is_stop  = in.valid && (in.tag == TAG_SEG_STOP);

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            state           <= SEG_IDLE;
            inst_cnt        <= '0;
            cycle_cnt       <= '0;
            seg_done        <= 1'b0;
            seg_inst_count  <= '0;
            seg_cycle_count <= '0;
            halted          <= 1'b0;
        end else begin
            seg_done <= 1'b0;
            if (in.valid && in.tag == TAG_HALT) begin
                halted <= 1'b1;
            end
            // A start marker restarts the segment from any state
            if (is_start) begin
                state     <= SEG_RUN;
                inst_cnt  <= '0;
                cycle_cnt <= '0;
            end else begin
                case (state)
                    SEG_IDLE: begin
                        state <= SEG_IDLE;
                    end
                    SEG_RUN: begin
                        cycle_cnt <= cycle_cnt + count_t'(1);
                        if (in.valid) begin
                            inst_cnt <= inst_cnt + count_t'(1);
                        end
                        // The stop marker itself is counted in both totals
                        if (is_stop) begin
                            seg_inst_count  <= inst_cnt + count_t'(1);
                            seg_cycle_count <= cycle_cnt + count_t'(1);
                            seg_done        <= 1'b1;
                            state           <= SEG_IDLE;
                        end
                    end
                    default: state <= SEG_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/order_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module order_checker (
    input  logic  itf,
    input  logic  arst_n,
    commit_if.snk in,
    output logic  order_error
);
    import mon_pkg::*;

    order_t expected_order;

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            expected_order <= '0;
            order_error    <= 1'b0;
        end else if (in.valid) begin
            if (in.order != expected_order) begin
                order_error <= 1'b1;
            end
            // Resynchronize on the observed order so one gap is flagged only once
            expected_order <= in.order + order_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== design/commit_monitor_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_monitor_top (
    input  logic              itf,
    input  logic              arst_n,
    input  logic              commit_valid,
    input  mon_pkg::order_t   commit_order,
    input  mon_pkg::word_t    commit_insn,
    input  mon_pkg::word_t    commit_pc,
    input  mon_pkg::reg_idx_t commit_rd_addr,
    input  mon_pkg::word_t    commit_rd_wdata,
    input  mon_pkg::word_t    commit_mem_addr,
    output logic              trace_valid,
    output mon_pkg::order_t   trace_order,
    output mon_pkg::word_t    trace_pc,
    output mon_pkg::reg_idx_t trace_rd_addr,
    output mon_pkg::word_t    trace_rd_wdata,
    output mon_pkg::word_t    trace_mem_addr,
    output logic              halted,
    output logic              seg_done,
    output mon_pkg::count_t   seg_inst_count,
    output mon_pkg::count_t   seg_cycle_count,
    output logic              order_error
);

    commit_if norm_bus ();
    commit_if class_bus ();

    commit_normalize u_normalize (
        .itf             (itf),
        .arst_n          (arst_n),
        .commit_valid    (commit_valid),
        .commit_order    (commit_order),
        .commit_insn     (commit_insn),
        .commit_pc       (commit_pc),
        .commit_rd_addr  (commit_rd_addr),
        .commit_rd_wdata (commit_rd_wdata),
        .commit_mem_addr (commit_mem_addr),
        .out             (norm_bus.src)
    );

    commit_classify u_classify (
        .itf    (itf),
        .arst_n (arst_n),
        .in     (norm_bus.snk),
        .out    (class_bus.src)
    );

    segment_counter u_segment_counter (
        .itf             (itf),
        .arst_n          (arst_n),
        .in              (class_bus.snk),
        .halted          (halted),
        .seg_done        (seg_done),
        .seg_inst_count  (seg_inst_count),
        .seg_cycle_count (seg_cycle_count)
    );

    order_checker u_order_checker (
        .itf         (itf),
        .arst_n      (arst_n),
        .in          (class_bus.snk),
        .order_error (order_error)
    );

    // Normalized trace leaves from the classified stage, two cycles after input
    assign trace_valid    = class_bus.valid;
    assign trace_order    = class_bus.order;
    assign trace_pc       = class_bus.pc;
    assign trace_rd_addr  = class_bus.rd_addr;
    assign trace_rd_wdata = class_bus.rd_wdata;
    assign trace_mem_addr = class_bus.mem_addr;

endmodule

`default_nettype wire

// ==== tests/tb_commit_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mon_config.svh"

module tb_commit_monitor;
    import mon_pkg::*;

    typedef struct packed {
        order_t   order;
        word_t    pc;
        reg_idx_t rd_addr;
        word_t    rd_wdata;
        word_t    mem_addr;
    } trace_rec_t;

    logic     itf = 1'b0;
    logic     arst_n;
    logic     commit_valid;
    order_t   commit_order;
    word_t    commit_insn, commit_pc, commit_rd_wdata, commit_mem_addr;
    reg_idx_t commit_rd_addr;
    logic     trace_valid;
    order_t   trace_order;
    word_t    trace_pc, trace_rd_wdata, trace_mem_addr;
    reg_idx_t trace_rd_addr;
    logic     halted, seg_done, order_error;
    count_t   seg_inst_count, seg_cycle_count;

    trace_rec_t expect_q[$];
    trace_rec_t head;
    order_t     next_order;
    word_t      halt_words [3];
    logic [1:0] valid_d;
    int         drive_edges = 0;
    int         done_pulses = 0;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    commit_monitor_top dut0 (.*);

    always #5 itf = ~itf;

    // Models the two register stages that valid passes through
    always @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            valid_d <= 2'b00;
        end else begin
            valid_d <= {valid_d[0], commit_valid};
        end
    end

    trace_latency: assert property (@(posedge itf) disable iff (!arst_n)
        trace_valid == valid_d[1])
        else begin
            $display("[FAIL] trace_valid: got 0x%0h, expected 0x%0h",
                     $sampled(trace_valid), $sampled(valid_d[1]));
            errors++;
        end

    always @(posedge itf) begin
        if (trace_valid) begin
            if (expect_q.size() == 0) begin
                $display("Trace record with order 0x%0h came out with no commit pending",
                         trace_order);
                errors++;
            end else begin
                head = expect_q.pop_front();
                check_value("trace_order", trace_order, head.order);
                check_value("trace_pc", 64'(trace_pc), 64'(head.pc));
                check_value("trace_rd_addr", 64'(trace_rd_addr), 64'(head.rd_addr));
                check_value("trace_rd_wdata", 64'(trace_rd_wdata), 64'(head.rd_wdata));
                check_value("trace_mem_addr", 64'(trace_mem_addr), 64'(head.mem_addr));
            end
        end
    end

    // Number of cycles in which seg_done was seen high
    always @(posedge itf) begin
        if (seg_done) begin
            done_pulses++;
        end
    end

    function automatic void check_value(input string name, input logic [63:0] got,
                                        input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endfunction

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic apply_reset();
        @(posedge itf);
        arst_n       <= 1'b0;
        commit_valid <= 1'b0;
        repeat (4) @(posedge itf);
        arst_n <= 1'b1;
        expect_q.delete();
        next_order = '0;
    endtask

    // R-type opcode, so no random word hits a halt or marker encoding
    function automatic word_t random_op();
        return ($urandom() & 32'hffff_ff80) | 32'h0000_0033;
    endfunction

    task automatic send_commit(input word_t insn);
        trace_rec_t rec;
        word_t      wdata;
        word_t      addr;
        rec.order   = next_order;
        rec.pc      = 32'h8000_0000 + {next_order[29:0], 2'b00};
        rec.rd_addr = ($urandom_range(3) == 0) ? 5'd0 : reg_idx_t'($urandom());
        wdata       = $urandom();
        addr        = $urandom();
        // Writes to x0 read back as zero and the address loses its byte offset
        rec.rd_wdata = (rec.rd_addr == 5'd0) ? 32'd0 : wdata;
        rec.mem_addr = addr & 32'hffff_fffc;
        @(posedge itf);
        commit_valid    <= 1'b1;
        commit_order    <= rec.order;
        commit_insn     <= insn;
        commit_pc       <= rec.pc;
        commit_rd_addr  <= rec.rd_addr;
        commit_rd_wdata <= wdata;
        commit_mem_addr <= addr;
        expect_q.push_back(rec);
        next_order++;
        drive_edges++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge itf);
            commit_valid <= 1'b0;
            drive_edges++;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0 && cycles < 20) begin
            @(negedge itf);
            cycles++;
        end
        if (expect_q.size() != 0) begin
            $display("%0d trace records still pending after 20 cycles", expect_q.size());
            errors++;
        end
    endtask

    initial begin
        int err_mark;
        int k;
        int seg_edges;
        void'($urandom(89320));
        halt_words[0]   = `MON_HALT_INSN0;
        halt_words[1]   = `MON_HALT_INSN1;
        halt_words[2]   = `MON_HALT_INSN2;
        arst_n          = 1'b0;
        commit_valid    = 1'b0;
        commit_order    = '0;
        commit_insn     = '0;
        commit_pc       = '0;
        commit_rd_addr  = '0;
        commit_rd_wdata = '0;
        commit_mem_addr = '0;
        apply_reset();

        err_mark = errors;
        @(negedge itf);
        check_value("trace_valid", 64'(trace_valid), 64'd0);
        check_value("halted", 64'(halted), 64'd0);
        check_value("seg_done", 64'(seg_done), 64'd0);
        check_value("order_error", 64'(order_error), 64'd0);
        check_value("seg_inst_count", 64'(seg_inst_count), 64'd0);
        check_value("seg_cycle_count", 64'(seg_cycle_count), 64'd0);
        finish_test("reset state", err_mark);

        err_mark = errors;
        repeat (40) begin
            send_commit(random_op());
            idle($urandom_range(2));
        end
        idle(1);
        wait_drain();
        check_value("order_error", 64'(order_error), 64'd0);
        finish_test("normalization", err_mark);

        err_mark = errors;
        done_pulses = 0;
        k = 3 + $urandom_range(5);
        send_commit(`MON_SEG_START_INSN);
        seg_edges = drive_edges;
        repeat (k) begin
            send_commit(random_op());
            idle($urandom_range(3));
        end
        send_commit(`MON_SEG_STOP_INSN);
        seg_edges = drive_edges - seg_edges;
        idle(1);
        // The totals are registered in the cycle the stop record leaves the trace
        wait_drain();
        check_value("seg_done", 64'(seg_done), 64'd1);
        check_value("seg_inst_count", 64'(seg_inst_count), 64'(k + 1));
        check_value("seg_cycle_count", 64'(seg_cycle_count), 64'(seg_edges));
        @(negedge itf);
        check_value("seg_done", 64'(seg_done), 64'd0);
        check_value("seg_done_pulses", 64'(done_pulses), 64'd1);
        finish_test("segment counting", err_mark);

        err_mark = errors;
        repeat (5) begin
            send_commit(random_op());
            idle($urandom_range(1));
        end
        idle(1);
        wait_drain();
        check_value("order_error", 64'(order_error), 64'd0);
        next_order++;
        send_commit(random_op());
        idle(1);
        wait_drain();
        check_value("order_error", 64'(order_error), 64'd1);
        repeat (3) begin
            send_commit(random_op());
            idle(1);
        end
        wait_drain();
        check_value("order_error", 64'(order_error), 64'd1);
        finish_test("order check", err_mark);

        for (int h = 0; h < 3; h++) begin
            err_mark = errors;
            apply_reset();
            // Halt word on the bus with valid low
            @(posedge itf);
            commit_insn <= halt_words[h];
            repeat (4) @(negedge itf);
            check_value("halted", 64'(halted), 64'd0);
            send_commit(halt_words[h]);
            idle(1);
            repeat (2) @(negedge itf);
            check_value("halted", 64'(halted), 64'd0);
            @(negedge itf);
            check_value("halted", 64'(halted), 64'd1);
            idle(5);
            @(negedge itf);
            check_value("halted", 64'(halted), 64'd1);
            finish_test($sformatf("halt encoding %0d", h), err_mark);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/mon_pkg.sv
design/commit_if.sv
design/commit_normalize.sv
design/commit_classify.sv
design/segment_counter.sv
design/order_checker.sv
design/commit_monitor_top.sv
tests/tb_commit_monitor.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_commit_monitor
FILELIST = filelist.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
